/* filelist.f */
+incdir+src
+incdir+bench
src/isa_pkg.sv
src/frontend_pkg.sv
src/fetch_pc_unit.sv
src/icache.sv
src/branch_predecoder.sv
src/instr_queue.sv
src/ifu.sv
bench/ifu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ifu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh bench/*.sv bench/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/ifu_tb_table.svh */
`ifndef IFU_TB_TABLE_SVH
`define IFU_TB_TABLE_SVH

// program image, plain words carry opcode 0x08 and their own index
task automatic fill_program();
    for (int i = 0; i < 64; i++) begin
        prog[i] = {6'h08, 26'(i)};
    end
    prog[10] = {`IFU_OP_BRZ, 5'd1, 5'd0, 16'h0003};  // forward, not taken
    prog[14] = {`IFU_OP_BRZ, 5'd2, 5'd0, 16'hfffa};  // back to word 8
    prog[20] = {`IFU_OP_JMP, 26'd12};                // 0x50 -> 0x80
    prog[36] = {`IFU_OP_JMP, 26'h3ffffdc};           // 0x90 -> 0x00
endtask

task automatic set_row(input int idx, input string name, input int n_instr,
                       input int stall_from, input int stall_to,
                       input int rec_at, input logic [31:0] rec_pc,
                       input bit gaps, input int pause_from, input int pause_len,
                       input bit cold);
    rows[idx].name       = name;
    rows[idx].n_instr    = n_instr;
    rows[idx].stall_from = stall_from;
    rows[idx].stall_to   = stall_to;
    rows[idx].rec_at     = rec_at; // -1 means no recovery
    rows[idx].rec_pc     = rec_pc;
    rows[idx].gaps       = gaps;
    rows[idx].pause_from = pause_from;
    rows[idx].pause_len  = pause_len;
    rows[idx].cold       = cold;
endtask

// name, count, stall window, recovery point and target, gaps, pause, cold check
task automatic fill_table();
    set_row(0, "cold_straight",  10, 0,  0,  -1, 32'h0,  1'b0, 0,  0,  1'b1);
    set_row(1, "branch_predict", 24, 0,  0,  -1, 32'h0,  1'b0, 0,  0,  1'b0);
    set_row(2, "jump_recover",   20, 0,  0,   2, 32'h40, 1'b0, 0,  0,  1'b0);
    set_row(3, "backpressure",   30, 0,  0,  -1, 32'h0,  1'b1, 15, 12, 1'b0);
    set_row(4, "backend_stall",  20, 5,  25, -1, 32'h0,  1'b0, 0,  0,  1'b0);
    set_row(5, "recovery_mix",   25, 10, 16,  7, 32'h84, 1'b1, 0,  0,  1'b0);
endtask

`endif

/* bench/ifu_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module ifu_tb;

    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 2000; // cycles per test

    typedef struct {
        string       name;
        int          n_instr;
        int          stall_from;
        int          stall_to;
        int          rec_at;
        logic [31:0] rec_pc;
        bit          gaps;
        int          pause_from;
        int          pause_len;
        bit          cold;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    logic        recovery_pc_valid;
    logic [31:0] recovery_pc;
    logic        backend_stall;
    logic        refill_data_valid;
    logic [63:0] refill_data;
    logic        dispatch_ready;
    logic        refill_req;
    logic [31:0] refill_addr;
    logic        instr_valid;
    logic [31:0] instr_out;
    logic [31:0] instr_pc;
    logic        instr_is_cond_br;
    logic        instr_pred_taken;
    logic [31:0] instr_pred_target;

    logic [31:0] prog [64];
    test_row_t   rows [NUM_TESTS];
    bit          req_seen [32]; // per block, cold test only
    int          cur_test;
    int          errors;
    int          test_errors;
    int          failed_tests;
    int          fills;
    logic [15:0] rdy_lfsr;

    `include "ifu_tb_table.svh"

    ifu dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .recovery_pc_valid (recovery_pc_valid),
        .recovery_pc       (recovery_pc),
        .backend_stall     (backend_stall),
        .refill_data_valid (refill_data_valid),
        .refill_data       (refill_data),
        .dispatch_ready    (dispatch_ready),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr),
        .instr_valid       (instr_valid),
        .instr_out         (instr_out),
        .instr_pc          (instr_pc),
        .instr_is_cond_br  (instr_is_cond_br),
        .instr_pred_taken  (instr_pred_taken),
        .instr_pred_target (instr_pred_target)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [15:0] s, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            s   = lfsr_step(s);
            val = (val << 1) | int'(s[0]); // one step per bit
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    // fetch rule applied to the image
    task automatic predict(input logic [31:0] p, output logic [31:0] word,
                           output logic is_br, output logic taken,
                           output logic [31:0] nxt);
        word  = prog[p[7:2]];
        is_br = 1'b0;
        taken = 1'b0;
        nxt   = p + 32'd4;
        if (word[31:26] == `IFU_OP_BRZ) begin
            is_br = 1'b1;
            taken = ($signed(word[15:0]) < 0); // backward branch
            if (taken) nxt = p + 32'(4 * $signed(word[15:0]));
        end else if (word[31:26] == `IFU_OP_JMP) begin
            taken = 1'b1;
            nxt   = p + 32'(4 * $signed(word[25:0]));
        end
    endtask

    function automatic logic [63:0] block_at(input logic [31:0] a);
        return {prog[{a[7:3], 1'b1}], prog[{a[7:3], 1'b0}]}; // upper word is pc+4
    endfunction

    // refill side, one outstanding miss with random latency
    initial begin : memory_model
        logic [15:0] mem_lfsr;
        logic [31:0] addr;
        int          wait_cycles;
        int          reqs;
        bit          busy;
        mem_lfsr = 16'd21;
        busy     = 1'b0;
        reqs     = 0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                busy = 1'b0;
                reqs = 0;
                refill_data_valid <= 1'b0;
            end else begin
                refill_data_valid <= 1'b0;
                if (busy) begin
                    check_val("refill_req", 64'(refill_req), 64'd0); // miss still pending
                    if (wait_cycles == 0) begin
                        refill_data_valid <= 1'b1;
                        refill_data       <= block_at(addr);
                        busy = 1'b0;
                        fills++;
                    end else begin
                        wait_cycles--;
                    end
                end else if (refill_req) begin
                    addr = refill_addr;
                    check_val("refill_addr[2:0]", 64'(addr[2:0]), 64'd0);
                    if (reqs == 0) check_val("refill_addr", 64'(addr), 64'd0); // reset vector
                    if (rows[cur_test].cold) begin
                        if (req_seen[addr[7:3]]) begin
                            $display("block %h requested twice on a cold cache", addr);
                            errors++;
                            test_errors++;
                        end
                        req_seen[addr[7:3]] = 1'b1;
                    end
                    reqs++;
                    busy = 1'b1;
                    take_bits(mem_lfsr, 2, wait_cycles); // 0..3 extra cycles
                end
            end
        end
    end

    function automatic bit ready_for(input int t, input int cyc, input int coin);
        if (cyc >= rows[t].pause_from && cyc < rows[t].pause_from + rows[t].pause_len)
            return 1'b0; // long pause
        if (rows[t].gaps) return coin[0];
        return 1'b1;
    endfunction

    task automatic run_test(input int t);
        int          cyc;
        int          got;
        int          coin;
        logic [31:0] exp_pc;
        logic [31:0] exp_word;
        logic [31:0] exp_next;
        logic        exp_br;
        logic        exp_taken;
        logic [31:0] held_pc;
        logic [31:0] held_out;
        bit          held;
        bit          recovered;
        cur_test    = t;
        test_errors = 0;
        @(posedge clk);
        rst_n             <= 1'b0;
        backend_stall     <= 1'b0;
        recovery_pc_valid <= 1'b0;
        dispatch_ready    <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n          <= 1'b1;
        dispatch_ready <= 1'b1;
        fills = 0; // memory model is idle after reset
        for (int i = 0; i < 32; i++) req_seen[i] = 1'b0;
        cyc       = 0;
        got       = 0;
        exp_pc    = 32'h0; // reset vector
        held      = 1'b0;
        recovered = (rows[t].rec_at < 0);
        while (got < rows[t].n_instr && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
            if (fills == 0) check_val("instr_valid", 64'(instr_valid), 64'd0);
            if (recovery_pc_valid) begin
                exp_pc = rows[t].rec_pc; // queue flushed this edge
                held   = 1'b0;
            end else begin
                if (held) begin
                    check_val("instr_valid", 64'(instr_valid), 64'd1);
                    check_val("instr_pc", 64'(instr_pc), 64'(held_pc));
                    check_val("instr_out", 64'(instr_out), 64'(held_out));
                end
                if (instr_valid && dispatch_ready) begin
                    predict(exp_pc, exp_word, exp_br, exp_taken, exp_next);
                    check_val("instr_pc", 64'(instr_pc), 64'(exp_pc));
                    check_val("instr_out", 64'(instr_out), 64'(exp_word));
                    check_val("instr_is_cond_br", 64'(instr_is_cond_br), 64'(exp_br));
                    check_val("instr_pred_taken", 64'(instr_pred_taken), 64'(exp_taken));
                    check_val("instr_pred_target", 64'(instr_pred_target), 64'(exp_next));
                    exp_pc = exp_next;
                    got++;
                end
                held     = instr_valid && !dispatch_ready;
                held_pc  = instr_pc;
                held_out = instr_out;
            end
            take_bits(rdy_lfsr, 1, coin);
            if (!recovered && got == rows[t].rec_at) begin
                recovery_pc_valid <= 1'b1;
                recovery_pc       <= rows[t].rec_pc;
                dispatch_ready    <= 1'b0; // no transfer in the flush cycle
                recovered = 1'b1;
            end else begin
                recovery_pc_valid <= 1'b0;
                dispatch_ready    <= ready_for(t, cyc, coin);
            end
            backend_stall <= (cyc >= rows[t].stall_from && cyc < rows[t].stall_to);
        end
        if (got < rows[t].n_instr) begin
            $display("timeout in %s: only %0d of %0d instructions dispatched",
                     rows[t].name, got, rows[t].n_instr);
            errors++;
            test_errors++;
        end
        recovery_pc_valid <= 1'b0;
        backend_stall     <= 1'b0;
        if (test_errors == 0) begin
            $display("test %0d %s: ok, %0d dispatched", t, rows[t].name, got);
        end else begin
            $display("test %0d %s: %0d errors", t, rows[t].name, test_errors);
            failed_tests++;
        end
    endtask

    initial begin
        rst_n             = 1'b0;
        recovery_pc_valid = 1'b0;
        recovery_pc       = 32'h0;
        backend_stall     = 1'b0;
        refill_data_valid = 1'b0;
        refill_data       = 64'h0;
        dispatch_ready    = 1'b0;
        errors       = 0;
        failed_tests = 0;
        cur_test     = 0;
        rdy_lfsr     = 16'd21;
        fill_program();
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/ifu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module ifu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        recovery_pc_valid,
    input  logic [`IFU_ADDR_WIDTH-1:0]  recovery_pc,
    input  logic                        backend_stall,
    input  logic                        refill_data_valid,
    input  logic [`IFU_BLOCK_BITS-1:0]  refill_data,
    input  logic                        dispatch_ready,
    output logic                        refill_req,
    output logic [`IFU_ADDR_WIDTH-1:0]  refill_addr,
    output logic                        instr_valid,
    output logic [`IFU_INSTR_WIDTH-1:0] instr_out,
    output logic [`IFU_ADDR_WIDTH-1:0]  instr_pc,
    output logic                        instr_is_cond_br,
    output logic                        instr_pred_taken,
    output logic [`IFU_ADDR_WIDTH-1:0]  instr_pred_target
);

    logic [`IFU_ADDR_WIDTH-1:0]  pc;
    logic [`IFU_ADDR_WIDTH-1:0]  next_pc;     // predicted
    logic                        hit;
    logic [`IFU_BLOCK_BITS-1:0]  block;
    logic [`IFU_INSTR_WIDTH-1:0] instruction; // word at pc
    logic                        is_cond_br;
    logic                        pred_taken;
    logic                        iq_full;
    logic                        stall;
    logic                        push;

    // anything that keeps the current pc from being consumed
    assign stall = !hit || iq_full || backend_stall;
    // wrong path word at pc is dropped on recovery
    assign push  = hit && !iq_full && !backend_stall && !recovery_pc_valid;

    fetch_pc_unit pc_unit (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall             (stall),
        .recovery_pc_valid (recovery_pc_valid),
        .recovery_pc       (recovery_pc),
        .next_pc           (next_pc),
        .pc                (pc)
    );

    icache icache (
        .clk               (clk),
        .rst_n             (rst_n),
        .pc                (pc),
        .refill_data_valid (refill_data_valid),
        .refill_data       (refill_data),
        .hit               (hit),
        .block             (block),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr)
    );

    branch_predecoder predecoder (
        .pc          (pc),
        .block       (block),
        .instruction (instruction),
        .is_cond_br  (is_cond_br),
        .pred_taken  (pred_taken),
        .next_pc     (next_pc)
    );

    instr_queue iq (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (recovery_pc_valid), // same cycle as the strobe
        .push              (push),
        .instruction       (instruction),
        .pc                (pc),
        .is_cond_br        (is_cond_br),
        .pred_taken        (pred_taken),
        .pred_target       (next_pc),
        .dispatch_ready    (dispatch_ready),
        .full              (iq_full),
        .instr_valid       (instr_valid),
        .instr_out         (instr_out),
        .instr_pc          (instr_pc),
        .instr_is_cond_br  (instr_is_cond_br),
        .instr_pred_taken  (instr_pred_taken),
        .instr_pred_target (instr_pred_target)
    );

endmodule

`default_nettype wire

/* src/instr_queue.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module instr_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,             // recovery, drop everything
    input  logic                        push,
    input  logic [`IFU_INSTR_WIDTH-1:0] instruction,
    input  logic [`IFU_ADDR_WIDTH-1:0]  pc,
    input  logic                        is_cond_br,
    input  logic                        pred_taken,
    input  logic [`IFU_ADDR_WIDTH-1:0]  pred_target,
    input  logic                        dispatch_ready,
    output logic                        full,
    output logic                        instr_valid,
    output logic [`IFU_INSTR_WIDTH-1:0] instr_out,
    output logic [`IFU_ADDR_WIDTH-1:0]  instr_pc,
    output logic                        instr_is_cond_br,
    output logic                        instr_pred_taken,
    output logic [`IFU_ADDR_WIDTH-1:0]  instr_pred_target
);

    import frontend_pkg::*;

    localparam int DEPTH    = `IFU_IQ_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    iq_entry_t           entries [DEPTH];
    iq_entry_t           wr_entry;
    iq_entry_t           head;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;  // one extra bit for full
    logic                pop;

    // wrap at DEPTH even when it is not a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_entry = '{instruction: instruction, pc: pc, is_cond_br: is_cond_br,
                        pred_taken: pred_taken, pred_target: pred_target};

    assign pop         = instr_valid && dispatch_ready; // transfer to dispatch
    assign full        = (count == (PTR_BITS + 1)'(DEPTH));
    assign instr_valid = (count != '0);

    // head slot drives dispatch
    assign head              = entries[rd_ptr];
    assign instr_out         = head.instruction;
    assign instr_pc          = head.pc;
    assign instr_is_cond_br  = head.is_cond_br;
    assign instr_pred_taken  = head.pred_taken;
    assign instr_pred_target = head.pred_target;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // slot storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= wr_entry;
        end
    end

    // top level gates push with full
    no_push_full_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    ) else $error("push into full instruction queue");

    // dispatch sees a stable head until it takes it
    head_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid && !dispatch_ready && !flush |=> instr_valid && $stable(head)
    ) else $error("dispatch head changed while stalled");

endmodule

`default_nettype wire

/* src/branch_predecoder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module branch_predecoder (
    input  logic [`IFU_ADDR_WIDTH-1:0]  pc,
    input  logic [`IFU_BLOCK_BITS-1:0]  block,       // hit block from icache
    output logic [`IFU_INSTR_WIDTH-1:0] instruction,
    output logic                        is_cond_br,
    output logic                        pred_taken,
    output logic [`IFU_ADDR_WIDTH-1:0]  next_pc
);

    import isa_pkg::*;

    // sign extension widths for word offsets shifted by two
    localparam int BR_EXT  = `IFU_ADDR_WIDTH - 16 - 2;
    localparam int JMP_EXT = `IFU_ADDR_WIDTH - 26 - 2;

    instr_word_u                word;
    opcode_t                    opcode;
    logic [`IFU_ADDR_WIDTH-1:0] seq_pc;
    logic [`IFU_ADDR_WIDTH-1:0] br_target;
    logic [`IFU_ADDR_WIDTH-1:0] jmp_target;

    // pc bit 2 picks the upper word of the block
    assign instruction = pc[2] ? block[`IFU_BLOCK_BITS-1 -: `IFU_INSTR_WIDTH]
                               : block[`IFU_INSTR_WIDTH-1:0];

    assign word   = instruction;
    assign opcode = word.br.opcode; // same bits in the jump view
    assign seq_pc = pc + `IFU_ADDR_WIDTH'(4);

    // both targets computed, opcode picks one
    assign br_target  = pc + {{BR_EXT{word.br.offset[15]}}, word.br.offset, 2'b00};
    assign jmp_target = pc + {{JMP_EXT{word.jmp.offset[25]}}, word.jmp.offset, 2'b00};

    always_comb begin
        is_cond_br = 1'b0;
        pred_taken = 1'b0;
        next_pc    = seq_pc; // fall through by default
        case (opcode)
            `IFU_OP_BRZ: begin
                is_cond_br = 1'b1;
                pred_taken = word.br.offset[15]; // backward taken, forward not
                if (word.br.offset[15]) begin
                    next_pc = br_target;
                end
            end
            `IFU_OP_JMP: begin
                pred_taken = 1'b1; // jumps always redirect
                next_pc    = jmp_target;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/icache.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module icache (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`IFU_ADDR_WIDTH-1:0] pc,
    input  logic                       refill_data_valid, // one cycle strobe
    input  logic [`IFU_BLOCK_BITS-1:0] refill_data,
    output logic                       hit,
    output logic [`IFU_BLOCK_BITS-1:0] block,
    output logic                       refill_req,        // one cycle strobe
    output logic [`IFU_ADDR_WIDTH-1:0] refill_addr        // block aligned
);

    import frontend_pkg::*;

    localparam int OFFSET_BITS = $clog2(`IFU_BLOCK_BITS / 8);
    localparam int INDEX_BITS  = $clog2(`IFU_ICACHE_SETS);
    localparam int TAG_BITS    = `IFU_ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    logic [`IFU_ICACHE_SETS-1:0] valid_q;
    logic [TAG_BITS-1:0]         tag_mem [`IFU_ICACHE_SETS];
    logic [`IFU_BLOCK_BITS-1:0]  data_mem [`IFU_ICACHE_SETS];

    refill_state_t              state;
    logic [`IFU_ADDR_WIDTH-1:0] pend_addr; // address of the outstanding miss
    logic [INDEX_BITS-1:0]      pc_index;
    logic [TAG_BITS-1:0]        pc_tag;
    logic [INDEX_BITS-1:0]      pend_index;
    logic [TAG_BITS-1:0]        pend_tag;
    logic                       fill_we;

    // address split
    assign pc_index   = pc[OFFSET_BITS +: INDEX_BITS];
    assign pc_tag     = pc[`IFU_ADDR_WIDTH-1 -: TAG_BITS];
    assign pend_index = pend_addr[OFFSET_BITS +: INDEX_BITS];
    assign pend_tag   = pend_addr[`IFU_ADDR_WIDTH-1 -: TAG_BITS];

    // lookup straight out of the registered arrays
    assign hit   = valid_q[pc_index] && (tag_mem[pc_index] == pc_tag);
    assign block = data_mem[pc_index];

    // only the first miss cycle requests, later cycles are pending
    assign refill_req  = !hit && (state == REFILL_IDLE);
    assign refill_addr = (state == REFILL_PENDING) ? pend_addr
                       : {pc[`IFU_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign fill_we = (state == REFILL_PENDING) && refill_data_valid;

    // refill tracker and valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= REFILL_IDLE;
            valid_q <= '0; // cold cache
        end else begin
            case (state)
                REFILL_IDLE: begin
                    if (refill_req) begin
                        state <= REFILL_PENDING;
                    end
                end
                REFILL_PENDING: begin
                    if (refill_data_valid) begin
                        state               <= REFILL_IDLE;
                        valid_q[pend_index] <= 1'b1;
                    end
                end
                default: state <= REFILL_IDLE;
            endcase
        end
    end

    // miss address capture and block write
    always_ff @(posedge clk) begin
        if (refill_req) begin
            pend_addr <= refill_addr;
        end
        if (fill_we) begin
            tag_mem[pend_index]  <= pend_tag;
            data_mem[pend_index] <= refill_data;
        end
    end

    // memory answers only a request we made
    no_stray_resp_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        refill_data_valid |-> state == REFILL_PENDING
    ) else $error("refill response with no miss outstanding");

endmodule

`default_nettype wire

/* src/fetch_pc_unit.sv */
`default_nettype none
`timescale 1ns/10ps

`include "ifu_config.svh"

module fetch_pc_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,             // miss, full queue or backend
    input  logic                       recovery_pc_valid,
    input  logic [`IFU_ADDR_WIDTH-1:0] recovery_pc,
    input  logic [`IFU_ADDR_WIDTH-1:0] next_pc,           // from predecoder
    output logic [`IFU_ADDR_WIDTH-1:0] pc
);

    localparam logic [`IFU_ADDR_WIDTH-1:0] RESET_VECTOR = '0;

    logic [`IFU_ADDR_WIDTH-1:0] pc_d;

    // pc mux
    always_comb begin
        if (recovery_pc_valid) begin
            pc_d = recovery_pc; // redirect beats everything
        end else if (stall) begin
            pc_d = pc;          // hold
        end else begin
            pc_d = next_pc;     // predicted path
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_d;
        end
    end

    // recovery targets come from the backend and must be word aligned too
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("fetch pc %h not word aligned", pc);

endmodule

`default_nettype wire

/* src/frontend_pkg.sv */
`default_nettype none

`include "ifu_config.svh"

package frontend_pkg;

    // one instruction queue slot, 98 bits
    typedef struct packed {
        logic [`IFU_INSTR_WIDTH-1:0] instruction;
        logic [`IFU_ADDR_WIDTH-1:0]  pc;
        logic                        is_cond_br;
        logic                        pred_taken;
        logic [`IFU_ADDR_WIDTH-1:0]  pred_target; // predicted next pc
    } iq_entry_t;

    // icache refill tracker
    typedef enum logic [1:0] {
        REFILL_IDLE    = 2'd0, // no miss outstanding
        REFILL_PENDING = 2'd1  // request sent, waiting for memory
    } refill_state_t;

endpackage

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

`include "ifu_config.svh"

package isa_pkg;

    typedef logic [5:0] opcode_t; // top six bits of every word

    // conditional branch format
    typedef struct packed {
        opcode_t     opcode; // [31:26]
        logic [4:0]  rs;     // [25:21] register tested
        logic [4:0]  unused; // [20:16]
        logic [15:0] offset; // signed, in words
    } instr_br_t;

    // jump format
    typedef struct packed {
        opcode_t     opcode; // [31:26]
        logic [25:0] offset; // signed, in words
    } instr_jmp_t;

    // one fetched word seen as either format
    typedef union packed {
        instr_br_t                   br;
        instr_jmp_t                  jmp;
        logic [`IFU_INSTR_WIDTH-1:0] raw;
    } instr_word_u;

endpackage

`default_nettype wire

/* src/ifu_config.svh */
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// datapath widths
`define IFU_ADDR_WIDTH  32 // byte address
`define IFU_INSTR_WIDTH 32

// icache geometry
`define IFU_BLOCK_BITS  64 // two instructions per block
`define IFU_ICACHE_SETS 16 // direct mapped

// instruction queue in front of dispatch
`define IFU_IQ_DEPTH 8

// primary opcodes the predecoder cares about
`define IFU_OP_BRZ 6'h04 // branch if rs is zero
`define IFU_OP_JMP 6'h02 // pc relative jump

`endif
